// ==== pdp8_pkg.sv ====
// accumulator section shared definitions
// word types, EAE sequencer states and instruction codes
`default_nettype none

package pdp8_pkg;

    // bit 0 is the most significant bit, as in the machine manuals
    typedef logic [0:11] word_t;

    typedef logic [4:0] step_count_t;  // EAE step counter

    typedef enum logic [1:0] {
        idle,
        setup,
        iterate,
        finish
    } eae_state_t;

    // IOT codes
    localparam word_t op_caf      = 12'o6007;  // clear all flags
    localparam word_t op_cla_iot  = 12'o6032;  // clear AC
    localparam word_t op_load_iot = 12'o6036;  // AC from device word

    // mode A EAE codes, compared after masking with eae_mask
    localparam word_t op_muy = 12'o7405;
    localparam word_t op_shl = 12'o7413;
    localparam word_t op_asr = 12'o7415;
    localparam word_t op_lsr = 12'o7417;

    // keeps the opcode bits and the EAE code bits, drops the MQ micro-op bits
    localparam word_t eae_mask = 12'o7417;

    // operate group prefixes, instruction bits 0 to 3
    localparam logic [0:3] group_one   = 4'b1110;
    localparam logic [0:3] group_three = 4'b1111;  // also needs bit 11 set

endpackage

`default_nettype wire

// ==== operate_unit.sv ====
// operate unit
// next AC, L and MQ for group-one and group-three micro-instructions
// and the three accumulator IOTs, purely combinational
`timescale 1ns/1ps
`default_nettype none

module operate_unit
    import pdp8_pkg::*;
(
    input  word_t instruction,
    input  word_t data_in,
    input  word_t ac,
    input  logic  link,
    input  word_t mq,
    output word_t op_ac,
    output logic  op_link,
    output word_t op_mq
);

    word_t g1_ac;      // group one after clear, complement and increment
    logic  g1_link;
    word_t rot_ac;     // group one after the rotate stage
    logic  rot_link;
    word_t g3_ac;
    word_t g3_mq;
    word_t cla_ac;     // AC after the group-three CLA bit

    // group one, fixed micro-op order
    always_comb
    begin
        g1_ac   = instruction[4] ? 12'o0000 : ac;      // CLA
        g1_link = instruction[5] ? 1'b0 : link;        // CLL
        if (instruction[6])
            g1_ac = ~g1_ac;                            // CMA
        if (instruction[7])
            g1_link = ~g1_link;                        // CML
        if (instruction[11])
            {g1_link, g1_ac} = {g1_link, g1_ac} + 13'd1;  // IAC, carry into L

        rot_ac   = g1_ac;
        rot_link = g1_link;
        case (instruction[8:10])
            3'b001: rot_ac = {g1_ac[6:11], g1_ac[0:5]};   // BSW
            3'b010:
            begin
                rot_ac   = {g1_ac[1:11], g1_link};         // RAL
                rot_link = g1_ac[0];
            end
            3'b011:
            begin
                rot_ac   = {g1_ac[2:11], g1_link, g1_ac[0]};  // RTL
                rot_link = g1_ac[1];
            end
            3'b100:
            begin
                rot_ac   = {g1_link, g1_ac[0:10]};         // RAR
                rot_link = g1_ac[11];
            end
            3'b101:
            begin
                rot_ac   = {g1_ac[11], g1_link, g1_ac[0:9]};  // RTR
                rot_link = g1_ac[10];
            end
            default: ;                                     // no rotate
        endcase
    end

    // group three, CLA first and then the MQ transfers
    always_comb
    begin
        cla_ac = instruction[4] ? 12'o0000 : ac;
        g3_ac  = cla_ac;
        g3_mq  = mq;
        case ({instruction[5], instruction[7]})           // MQA, MQL
            2'b11:
            begin
                g3_ac = mq;                                // SWP
                g3_mq = cla_ac;
            end
            2'b10: g3_ac = cla_ac | mq;                    // MQA, ACL with CLA
            2'b01:
            begin
                g3_mq = cla_ac;                            // MQL, CAM with CLA
                g3_ac = 12'o0000;
            end
            default: ;
        endcase
    end

    // pick the result by instruction class
    always_comb
    begin
        op_ac   = ac;
        op_link = link;
        op_mq   = mq;
        if (instruction[0:3] == group_one)
        begin
            op_ac   = rot_ac;
            op_link = rot_link;
        end
        else if (instruction[0:3] == group_three && instruction[11])
        begin
            op_ac = g3_ac;
            op_mq = g3_mq;
        end
        else if (instruction == op_caf)
        begin
            op_ac   = 12'o0000;
            op_link = 1'b0;
            op_mq   = 12'o0000;
        end
        else if (instruction == op_cla_iot)
            op_ac = 12'o0000;
        else if (instruction == op_load_iot)
            op_ac = data_in;                               // device word into AC
    end

endmodule

`default_nettype wire

// ==== eae_unit.sv ====
// extended arithmetic element, mode A
// sequencer and datapath for MUY, SHL, ASR and LSR; one setup cycle,
// one cycle per step, then a done cycle. works on the live AC, L and MQ
`timescale 1ns/1ps
`default_nettype none

module eae_unit
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  eae_start,
    input  word_t instruction,
    input  word_t data_in,
    input  word_t ac,
    input  logic  link,
    input  word_t mq,
    output logic  eae_write,
    output word_t eae_ac,
    output logic  eae_link,
    output word_t eae_mq,
    output logic  eae_busy,
    output logic  eae_done
);

    localparam step_count_t muy_steps   = 5'd12;
    localparam step_count_t shift_limit = 5'd24;  // at or above, result is saturated

    eae_state_t  state;
    step_count_t step_count;
    word_t       op_code;      // latched instruction
    word_t       operand;      // latched operand word
    word_t       eae_code;
    step_count_t shift_count;
    logic        saturate;
    word_t       sum_ac;
    logic        carry;

    assign eae_code    = op_code & eae_mask;
    assign shift_count = operand[7:11];
    assign saturate    = (eae_code != op_muy) && (shift_count >= shift_limit);

    assign {carry, sum_ac} = {1'b0, ac} + {1'b0, operand};  // MUY partial sum

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= idle;
            step_count <= '0;
        end
        else
        begin
            case (state)
                idle, finish:
                    state <= eae_start ? setup : idle;
                setup:
                begin
                    if (eae_code == op_muy)
                    begin
                        step_count <= muy_steps;
                        state      <= iterate;
                    end
                    else if (saturate)
                    begin
                        step_count <= '0;               // skip the loop
                        state      <= finish;
                    end
                    else
                    begin
                        step_count <= shift_count + 5'd1;  // mode A shifts count+1
                        state      <= iterate;
                    end
                end
                iterate:
                begin
                    step_count <= step_count - 5'd1;
                    if (step_count == 5'd1)
                        state <= finish;
                end
                default: state <= idle;
            endcase
        end
    end

    // instruction and operand are sampled in the start cycle only
    always_ff @(posedge clk)
    begin
        if (eae_start)
        begin
            op_code <= instruction;
            operand <= data_in;
        end
    end

    always_comb
    begin
        eae_write = 1'b0;
        eae_ac    = ac;
        eae_link  = link;
        eae_mq    = mq;
        case (state)
            setup:
                if (saturate)
                begin
                    eae_write = 1'b1;
                    if (eae_code == op_asr && ac[0])
                    begin
                        eae_ac   = 12'o7777;            // negative fills with ones
                        eae_mq   = 12'o7777;
                        eae_link = 1'b1;
                    end
                    else
                    begin
                        eae_ac   = 12'o0000;
                        eae_mq   = 12'o0000;
                        eae_link = 1'b0;
                    end
                end
            iterate:
            begin
                eae_write = 1'b1;
                case (eae_code)
                    op_muy:
                        if (mq[11])
                            {eae_ac, eae_mq} = {carry, sum_ac, mq[0:10]};  // add then shift
                        else
                            {eae_ac, eae_mq} = {1'b0, ac, mq[0:10]};
                    op_shl:
                        {eae_link, eae_ac, eae_mq} = {ac, mq, 1'b0};
                    op_asr:
                    begin
                        {eae_ac, eae_mq} = {ac[0], ac, mq[0:10]};  // sign extends
                        eae_link = ac[0];
                    end
                    op_lsr:
                    begin
                        {eae_ac, eae_mq} = {1'b0, ac, mq[0:10]};
                        eae_link = 1'b0;
                    end
                    default: eae_write = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

    assign eae_busy = (state == setup) || (state == iterate);
    assign eae_done = (state == finish);  // final result already in the registers

endmodule

`default_nettype wire

// ==== accumulator_file.sv ====
// accumulator register file
// holds AC, L and MQ, decodes each started instruction and merges the
// operate result and the EAE writes into the registers
`timescale 1ns/1ps
`default_nettype none

module accumulator_file
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t instruction,
    input  word_t op_ac,
    input  logic  op_link,
    input  word_t op_mq,
    input  logic  eae_write,
    input  word_t eae_ac,
    input  logic  eae_link,
    input  word_t eae_mq,
    input  logic  eae_busy,
    input  logic  eae_done,
    output word_t ac,
    output logic  link,
    output word_t mq,
    output logic  eae_start,
    output logic  busy,
    output logic  done
);

    word_t eae_code;
    logic  is_eae;
    logic  accept;      // start taken while no EAE loop runs
    logic  op_write;
    logic  op_done;     // done for operate and IOT codes

    assign eae_code = instruction & eae_mask;
    assign is_eae   = (eae_code == op_muy) || (eae_code == op_shl) ||
                      (eae_code == op_asr) || (eae_code == op_lsr);

    assign accept    = start && !eae_busy;   // a start while busy is dropped
    assign eae_start = accept && is_eae;
    assign op_write  = accept && !is_eae;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ac      <= 12'o0000;
            link    <= 1'b0;
            mq      <= 12'o0000;
            op_done <= 1'b0;
        end
        else
        begin
            op_done <= op_write;
            if (op_write)
            begin
                ac   <= op_ac;
                link <= op_link;
                mq   <= op_mq;
            end
            else if (eae_write)
            begin
                ac   <= eae_ac;
                link <= eae_link;
                mq   <= eae_mq;
            end
        end
    end

    assign busy = eae_busy;
    assign done = op_done || eae_done;   // never both in one cycle

endmodule

`default_nettype wire

// ==== ac_top.sv ====
// accumulator section top level
// connects the operate unit, the EAE and the register file
`timescale 1ns/1ps
`default_nettype none

module ac_top
    import pdp8_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  word_t instruction,
    input  word_t data_in,
    output word_t ac,
    output logic  link,
    output word_t mq,
    output logic  busy,
    output logic  done
);

    word_t op_ac;
    logic  op_link;
    word_t op_mq;
    logic  eae_start;
    logic  eae_write;
    word_t eae_ac;
    logic  eae_link;
    word_t eae_mq;
    logic  eae_busy;
    logic  eae_done;

    operate_unit u_operate (
        .instruction (instruction),
        .data_in     (data_in),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .op_ac       (op_ac),
        .op_link     (op_link),
        .op_mq       (op_mq)
    );

    eae_unit u_eae (
        .clk         (clk),
        .rst         (rst),
        .eae_start   (eae_start),
        .instruction (instruction),
        .data_in     (data_in),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .eae_write   (eae_write),
        .eae_ac      (eae_ac),
        .eae_link    (eae_link),
        .eae_mq      (eae_mq),
        .eae_busy    (eae_busy),
        .eae_done    (eae_done)
    );

    accumulator_file u_acc (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .instruction (instruction),
        .op_ac       (op_ac),
        .op_link     (op_link),
        .op_mq       (op_mq),
        .eae_write   (eae_write),
        .eae_ac      (eae_ac),
        .eae_link    (eae_link),
        .eae_mq      (eae_mq),
        .eae_busy    (eae_busy),
        .eae_done    (eae_done),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .eae_start   (eae_start),
        .busy        (busy),
        .done        (done)
    );

endmodule

`default_nettype wire

// ==== ac_top_chk.sv ====
// protocol checker for the accumulator section
// start, busy and done rules at the top level, bound into ac_top
`timescale 1ns/1ps
`default_nettype none

module ac_top_chk
    import pdp8_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  start,
    input word_t instruction,
    input logic  busy,
    input logic  done
);

    int   exclusive_fails = 0;
    int   latency_fails = 0;
    int   fall_fails = 0;
    logic is_eae;

    assign is_eae = ((instruction & eae_mask) == op_muy) || ((instruction & eae_mask) == op_shl) ||
                    ((instruction & eae_mask) == op_asr) || ((instruction & eae_mask) == op_lsr);

    a_not_both: assert property (@(posedge clk) disable iff (rst) !(busy && done))
    else
    begin
        $error("busy and done high in the same cycle");
        exclusive_fails++;
    end

    // operate codes and IOTs finish in the next cycle
    a_op_latency: assert property (@(posedge clk) disable iff (rst)
        start && !busy && !is_eae |=> done)
    else
    begin
        $error("no done one cycle after an operate or IOT start");
        latency_fails++;
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> done)
    else
    begin
        $error("busy fell without a done pulse");
        fall_fails++;
    end

endmodule

bind ac_top ac_top_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .instruction (instruction),
    .busy        (busy),
    .done        (done)
);

`default_nettype wire

// ==== tb_ac_top.sv ====
// testbench for the accumulator section
// runs each line of ac_stimulus.txt through the DUT and checks AC, L and MQ,
// plus the done latency and the busy level of every instruction
`timescale 1ns/1ps
`default_nettype none

module tb_ac_top;

    localparam int clk_half     = 20;   // 40 ns period
    localparam int reset_cycles = 10;
    localparam int done_timeout = 100;  // cycles allowed per instruction

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic [11:0] instruction;
    logic [11:0] data_in;
    logic [11:0] ac;
    logic        link;
    logic [11:0] mq;
    logic        busy;
    logic        done;

    int   value_errors;
    int   timing_errors;
    int   timeouts;
    int   other_errors;
    int   steps_run;
    logic aborted;        // set on a timeout, stops the stimulus loop

    ac_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .instruction (instruction),
        .data_in     (data_in),
        .ac          (ac),
        .link        (link),
        .mq          (mq),
        .busy        (busy),
        .done        (done)
    );

    always #clk_half clk = ~clk;

    // mode A EAE codes, after masking with 7417
    function automatic logic is_eae_code(input logic [11:0] code);
        logic [11:0] masked;
        masked = code & 12'o7417;
        return (masked == 12'o7405) || (masked == 12'o7413) ||
               (masked == 12'o7415) || (masked == 12'o7417);
    endfunction

    // one instruction: start strobe, wait for done, compare registers
    task automatic run_step(input logic [11:0] instr, input logic [11:0] operand,
                            input logic [11:0] exp_ac, input logic exp_link,
                            input logic [11:0] exp_mq);
        int   cycles;
        logic seen_busy;
        seen_busy = 1'b0;
        @(posedge clk);
        start       <= 1'b1;
        instruction <= instr;
        data_in     <= operand;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);           // sample between edges
        cycles = 1;
        while (!done && cycles < done_timeout)
        begin
            if (busy)
                seen_busy = 1'b1;
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!done)
        begin
            $display("timed out waiting for done after instruction %o", instr);
            timeouts = timeouts + 1;
            aborted  = 1'b1;
        end
        else
        begin
            if (ac !== exp_ac || link !== exp_link || mq !== exp_mq)
            begin
                $display("FAILED at %0t: %o got ac %o l %b mq %o, expected ac %o l %b mq %o",
                         $time, instr, ac, link, mq, exp_ac, exp_link, exp_mq);
                value_errors = value_errors + 1;
            end
            if (!is_eae_code(instr) && cycles != 1)
            begin
                $display("FAILED at %0t: %o done after %0d cycles, expected 1",
                         $time, instr, cycles);
                timing_errors = timing_errors + 1;
            end
            if (is_eae_code(instr) && !seen_busy)
            begin
                $display("FAILED at %0t: %o never raised busy before done", $time, instr);
                timing_errors = timing_errors + 1;
            end
        end
        steps_run = steps_run + 1;
    endtask

    initial
    begin
        int          fd;
        int          status;
        int          assert_fails;
        string       line;
        logic [11:0] f_instr;
        logic [11:0] f_data;
        logic [11:0] f_ac;
        logic        f_link;
        logic [11:0] f_mq;
        rst           = 1'b1;
        start         = 1'b0;
        instruction   = 12'o0000;
        data_in       = 12'o0000;
        value_errors  = 0;
        timing_errors = 0;
        timeouts      = 0;
        other_errors  = 0;
        steps_run     = 0;
        aborted       = 1'b0;

        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (ac !== 12'o0000 || link !== 1'b0 || mq !== 12'o0000 || busy !== 1'b0 ||
            done !== 1'b0)
        begin
            $display("FAILED at %0t: registers or flags not clear after reset", $time);
            value_errors = value_errors + 1;
        end

        fd = $fopen("ac_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file ac_stimulus.txt");
            other_errors = other_errors + 1;
        end
        else
        begin
            while (!$feof(fd) && !aborted)
            begin
                status = $fgets(line, fd);
                if (status != 0 &&
                    $sscanf(line, "%o %o %o %o %o", f_instr, f_data, f_ac, f_link, f_mq) == 5)
                    run_step(f_instr, f_data, f_ac, f_link, f_mq);   // comment lines fall through
            end
            $fclose(fd);
        end
        if (steps_run == 0)
        begin
            $display("no instruction lines were read from the stimulus file");
            other_errors = other_errors + 1;
        end

        assert_fails = u_dut.u_chk.exclusive_fails + u_dut.u_chk.latency_fails +
                       u_dut.u_chk.fall_fails;
        $display("steps %0d, errors: value %0d, timing %0d, timeout %0d, assertion %0d, other %0d",
                 steps_run, value_errors, timing_errors, timeouts, assert_fails, other_errors);
        if (value_errors + timing_errors + timeouts + assert_fails + other_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ac_stimulus.txt ====
# columns, all octal: instruction  data_in  expected_ac  expected_link  expected_mq
# one instruction per line, register state carries from line to line
6036 1234 1234 0 0000
7421 0000 0000 0 1234
6036 5670 5670 0 1234
7020 0000 5670 1 1234
6007 0000 0000 0 0000
6036 7777 7777 0 0000
6032 0000 0000 0 0000
7241 0000 0000 1 0000
6036 4321 4321 1 0000
7004 0000 0643 1 0000
7012 0000 6150 1 0000
7002 0000 5061 1 0000
7340 0000 7777 0 0000
7001 0000 0000 1 0000
7010 0000 4000 0 0000
7006 0000 0001 0 0000
6036 0017 0017 0 0000
7421 0000 0000 0 0017
6036 0300 0300 0 0017
7501 0000 0317 0 0017
7521 0000 0017 0 0317
7701 0000 0317 0 0317
6036 2222 2222 0 0317
7721 0000 0317 0 0000
7621 0000 0000 0 0000
6036 0012 0012 0 0000
7421 0000 0000 0 0012
7405 0013 0000 0 0156
6036 4000 4000 0 0156
7421 0000 0000 0 4000
6036 0005 0005 0 4000
7405 0003 0001 0 4005
6036 7777 7777 0 4005
7421 0000 0000 0 7777
6036 7777 7777 0 7777
7405 7777 7777 0 0000
6036 0003 0003 0 0000
7421 0000 0000 0 0003
6036 0001 0001 0 0003
7413 0002 0010 0 0030
7413 0010 0003 1 0000
6036 0707 0707 1 0000
7421 0000 0000 1 0707
6036 6000 6000 1 0707
7415 0001 7400 1 0161
7417 0003 0360 0 0007
6036 4000 4000 0 0007
7415 0030 7777 1 7777
7417 0037 0000 0 0000
6036 0001 0001 0 0000
7421 0000 0000 0 0001
6036 1234 1234 0 0001
7413 0027 0000 1 0000
6036 5555 5555 1 0000
7413 0030 0000 0 0000

// ==== list.f ====
pdp8_pkg.sv
operate_unit.sv
eae_unit.sv
accumulator_file.sv
ac_top.sv
ac_top_chk.sv
tb_ac_top.sv
